// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - common/dmem_pkg.sv
      - store_buffer/store_buffer.sv
      - hw/lsu_ctrl.sv
      - hw/data_mem.sv
      - hw/mem_stage.sv
  - target: test
    files:
      - tests/tb_mem_stage.sv

// File: common/dmem_pkg.sv
package dmem_pkg;

    localparam int ADDR_SIZE  = 32;    // byte address width
    localparam int WORD_SIZE  = 32;
    localparam int SB_ENTRIES = 2;     // store buffer depth, kept a power of two
    localparam int MEM_WORDS  = 256;   // data memory depth in words

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;

    // one core access, valid together with store_req_i or load_req_i
    typedef struct packed {
        logic [ADDR_SIZE-1:0] addr;
        logic [WORD_SIZE-1:0] data;    // store data, right-aligned
        mem_size_e            size;
    } mem_req_t;

    typedef struct packed {
        logic [ADDR_SIZE-3:0] widx;    // word index
        logic [WORD_SIZE-1:0] wdata;
        logic [3:0]           be;      // byte enables, lane 0 is bits 7:0
        logic                 we;      // low means read
    } mem_port_t;

    // oldest buffer entry, offered to the memory port
    typedef struct packed {
        logic                 valid;
        logic [ADDR_SIZE-3:0] widx;
        logic [WORD_SIZE-1:0] data;    // already sitting at its byte lanes
        logic [3:0]           be;
    } sb_drain_t;

    // byte lanes touched by an aligned access
    function automatic logic [3:0] size_be(mem_size_e size, logic [1:0] off);
        case (size)
            BYTE:    return 4'b0001 << off;
            HALF:    return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    // pick the addressed bytes out of a word, zero-extended and right-aligned
    function automatic logic [WORD_SIZE-1:0] load_extract(logic [WORD_SIZE-1:0] word,
                                                          logic [1:0]           off,
                                                          mem_size_e            size);
        logic [WORD_SIZE-1:0] shifted;
        shifted = word >> {off, 3'b000};
        case (size)
            BYTE:    return {{(WORD_SIZE-8){1'b0}}, shifted[7:0]};
            HALF:    return {{(WORD_SIZE-16){1'b0}}, shifted[15:0]};
            default: return shifted;
        endcase
    endfunction

endpackage

// File: hw/data_mem.sv
`timescale 1ns/100ps

module data_mem
    import dmem_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  mem_port_t            port_i,
    output logic [WORD_SIZE-1:0] rdata_o     // valid one cycle after the read
);

    logic [3:0][7:0]              mem_q [MEM_WORDS];   // contents undefined until written
    logic [$clog2(MEM_WORDS)-1:0] idx;

    assign idx = port_i.widx[$clog2(MEM_WORDS)-1:0];   // upper index bits ignored

    // per-byte write at the edge
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (port_i.we && port_i.be[b]) begin
                mem_q[idx][b] <= port_i.wdata[8*b +: 8];
            end
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= mem_q[idx];
        end
    end

    // writes beyond the array would alias onto low words
    a_write_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        port_i.we |-> (port_i.widx < MEM_WORDS));

endmodule

// File: hw/lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl
    import dmem_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 load_req_i,
    input  mem_req_t             req_i,
    input  logic                 sb_hit_i,
    input  logic                 sb_conflict_i,
    input  logic [WORD_SIZE-1:0] sb_fwd_data_i,
    input  sb_drain_t            sb_drain_i,
    output logic                 drain_grant_o,
    output mem_port_t            port_o,
    input  logic [WORD_SIZE-1:0] rdata_i,
    output logic                 stall_o,
    output logic                 load_valid_o,
    output logic [WORD_SIZE-1:0] load_data_o
);

    logic                 load_acc;    // load accepted this cycle
    logic                 load_miss;   // accepted and needs the memory
    logic                 valid_q;
    logic                 miss_q;      // response comes from rdata_i
    logic [1:0]           off_q;
    mem_size_e            size_q;
    logic [WORD_SIZE-1:0] fwd_q;

    assign load_acc      = load_req_i && !sb_conflict_i;
    assign load_miss     = load_acc && !sb_hit_i;
    assign stall_o       = sb_conflict_i;
    assign drain_grant_o = !load_miss;   // buffer owns the port otherwise

    // memory port mux, a load miss reads and everything else drains
    always_comb begin
        if (load_miss) begin
            port_o.widx  = req_i.addr[ADDR_SIZE-1:2];
            port_o.wdata = '0;
            port_o.be    = '0;
            port_o.we    = 1'b0;
        end else begin
            port_o.widx  = sb_drain_i.widx;
            port_o.wdata = sb_drain_i.data;
            port_o.be    = sb_drain_i.be;
            port_o.we    = sb_drain_i.valid;   // idle reads are harmless
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            miss_q  <= 1'b0;
        end else begin
            valid_q <= load_acc;
            miss_q  <= load_miss;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_acc) begin
            off_q  <= req_i.addr[1:0];   // needed to slice the memory word
            size_q <= req_i.size;
            fwd_q  <= sb_fwd_data_i;
        end
    end

    assign load_valid_o = valid_q;
    assign load_data_o  = miss_q ? load_extract(rdata_i, off_q, size_q) : fwd_q;

    // a missing load never reads a word still waiting in the drain slot
    a_no_stale_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_miss |-> !(sb_drain_i.valid && (sb_drain_i.widx == req_i.addr[ADDR_SIZE-1:2])));

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/100ps

module mem_stage
    import dmem_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 store_req_i,
    input  logic                 load_req_i,
    input  mem_req_t             req_i,
    output logic                 stall_o,
    output logic                 load_valid_o,
    output logic [WORD_SIZE-1:0] load_data_o
);

    logic                 sb_hit;
    logic                 sb_conflict;
    logic [WORD_SIZE-1:0] sb_fwd_data;
    sb_drain_t            sb_drain;
    logic                 drain_grant;   // port handed to the buffer
    mem_port_t            port;
    logic [WORD_SIZE-1:0] rdata;

    store_buffer i_store_buffer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .store_req_i   (store_req_i),
        .load_req_i    (load_req_i),
        .req_i         (req_i),
        .drain_grant_i (drain_grant),
        .hit_o         (sb_hit),
        .conflict_o    (sb_conflict),
        .fwd_data_o    (sb_fwd_data),
        .drain_o       (sb_drain)
    );

    lsu_ctrl i_lsu_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .load_req_i    (load_req_i),
        .req_i         (req_i),
        .sb_hit_i      (sb_hit),
        .sb_conflict_i (sb_conflict),
        .sb_fwd_data_i (sb_fwd_data),
        .sb_drain_i    (sb_drain),
        .drain_grant_o (drain_grant),
        .port_o        (port),
        .rdata_i       (rdata),
        .stall_o       (stall_o),
        .load_valid_o  (load_valid_o),
        .load_data_o   (load_data_o)
    );

    data_mem i_data_mem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .port_i  (port),
        .rdata_o (rdata)
    );

endmodule

// File: list.f
common/dmem_pkg.sv
store_buffer/store_buffer.sv
hw/lsu_ctrl.sv
hw/data_mem.sv
hw/mem_stage.sv
tests/tb_mem_stage.sv

// File: store_buffer/store_buffer.sv
`timescale 1ns/100ps

module store_buffer
    import dmem_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 store_req_i,
    input  logic                 load_req_i,
    input  mem_req_t             req_i,
    input  logic                 drain_grant_i,   // memory port is ours this cycle
    output logic                 hit_o,
    output logic                 conflict_o,
    output logic [WORD_SIZE-1:0] fwd_data_o,      // load data, already extracted
    output sb_drain_t            drain_o
);

    localparam int PTR_SIZE = (SB_ENTRIES > 1) ? $clog2(SB_ENTRIES) : 1;

    // payload of one entry, valid bits live in valid_q
    typedef struct packed {
        logic [ADDR_SIZE-1:0] addr;    // byte address of the first store
        logic [3:0][7:0]      data;    // byte lanes of the word
        mem_size_e            size;    // size of the first store
    } sb_entry_t;

    sb_entry_t [SB_ENTRIES-1:0] entries;
    logic [SB_ENTRIES-1:0]      valid_q;
    logic [PTR_SIZE-1:0]        head_q;     // next free slot
    logic [PTR_SIZE-1:0]        tail_q;     // oldest entry
    logic [SB_ENTRIES-1:0]      hit_vec;
    logic [PTR_SIZE-1:0]        hit_idx;
    logic                       hit;
    logic                       full;
    logic [3:0]                 req_be;
    logic [3:0]                 held_be;
    logic [WORD_SIZE-1:0]       st_lanes;
    logic                       store_ok;
    logic                       drain_fire;

    // word-granular tag compare
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < SB_ENTRIES; i++) begin
            hit_vec[i] = valid_q[i] &&
                         (entries[i].addr[ADDR_SIZE-1:2] == req_i.addr[ADDR_SIZE-1:2]);
            // a store cycle always drains the tail, so a store into it
            // must open a new entry instead of merging
            if (store_req_i && (PTR_SIZE'(i) == tail_q)) begin
                hit_vec[i] = 1'b0;
            end
            if (hit_vec[i]) begin
                hit_idx |= PTR_SIZE'(i);
            end
        end
    end

    assign hit      = |hit_vec;
    assign full     = &valid_q;
    assign req_be   = size_be(req_i.size, req_i.addr[1:0]);
    assign held_be  = size_be(entries[hit_idx].size, entries[hit_idx].addr[1:0]);   // merges stay inside
    assign st_lanes = req_i.data << {req_i.addr[1:0], 3'b000};   // move store bytes to their lanes

    assign hit_o = hit && (store_req_i || load_req_i);

    always_comb begin
        conflict_o = 1'b0;
        if (store_req_i || load_req_i) begin
            if (hit) begin
                conflict_o = |(req_be & ~held_be);   // needs bytes the entry never held
            end else if (store_req_i) begin
                conflict_o = full;                   // nowhere to put a new word
            end
        end
    end

    assign fwd_data_o = load_extract(entries[hit_idx].data, req_i.addr[1:0], req_i.size);

    // oldest entry goes out with its lane mask
    assign drain_o.valid = valid_q[tail_q];
    assign drain_o.widx  = entries[tail_q].addr[ADDR_SIZE-1:2];
    assign drain_o.data  = entries[tail_q].data;
    assign drain_o.be    = size_be(entries[tail_q].size, entries[tail_q].addr[1:0]);

    assign store_ok   = store_req_i && !conflict_o;
    assign drain_fire = drain_grant_i && valid_q[tail_q];

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (drain_fire) begin
                valid_q[tail_q] <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            if (store_ok && !hit) begin          // head != tail here unless empty
                valid_q[head_q] <= 1'b1;
                head_q          <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (store_ok) begin
            if (hit) begin
                // merge only the lanes this store writes
                for (int b = 0; b < 4; b++) begin
                    if (req_be[b]) begin
                        entries[hit_idx].data[b] <= st_lanes[8*b +: 8];
                    end
                end
            end else begin
                entries[head_q].addr <= req_i.addr;
                entries[head_q].data <= st_lanes;   // lanes outside size are masked later
                entries[head_q].size <= req_i.size;
            end
        end
    end

    // at most one entry can hold a given word
    a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (store_req_i || load_req_i) |-> $onehot0(hit_vec));

    // a new entry only lands in a free slot
    a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (store_ok && !hit) |-> !valid_q[head_q]);

    // entries are in order, so an empty tail means an empty buffer
    a_drain_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (drain_grant_i && !valid_q[tail_q]) |-> (valid_q == '0));

endmodule

// File: tests/tb_mem_stage.sv
`timescale 1ns/100ps

module tb_mem_stage
    import dmem_pkg::*;
();

    localparam int TIMEOUT = 50;   // cycles any single wait may take

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 store_req_i;
    logic                 load_req_i;
    mem_req_t             req_i;
    logic                 stall_o;
    logic                 load_valid_o;
    logic [WORD_SIZE-1:0] load_data_o;

    logic [7:0] ref_mem [MEM_WORDS*4];   // byte view of what the core has stored
    integer     seed;
    int         errors;
    int         timeouts;
    int         checks;

    mem_stage i_mem_stage (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .store_req_i  (store_req_i),
        .load_req_i   (load_req_i),
        .req_i        (req_i),
        .stall_o      (stall_o),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;   // 4 ns period

    function automatic int num_bytes(input mem_size_e size);
        case (size)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    // zero-extended, right-aligned value the core should see
    function automatic logic [WORD_SIZE-1:0] ref_load(input logic [ADDR_SIZE-1:0] addr,
                                                      input mem_size_e            size);
        logic [WORD_SIZE-1:0] val;
        val = '0;
        for (int i = 0; i < num_bytes(size); i++) begin
            val[8*i +: 8] = ref_mem[addr + i];   // little endian lanes
        end
        return val;
    endfunction

    // called at the drive point, returns there with the strobes low
    task automatic idle(input int n);
        store_req_i = 1'b0;
        load_req_i  = 1'b0;
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    // holds the store until stall_o drops, then updates the reference
    task automatic store_op(input logic [ADDR_SIZE-1:0] addr,
                            input logic [WORD_SIZE-1:0] data,
                            input mem_size_e            size);
        int cnt;
        cnt         = 0;
        req_i.addr  = addr;
        req_i.data  = data;
        req_i.size  = size;
        load_req_i  = 1'b0;
        store_req_i = 1'b1;
        @(negedge clk_i);
        while (stall_o && cnt < TIMEOUT) begin
            cnt++;
            @(negedge clk_i);
        end
        if (stall_o) begin
            timeouts++;
            $display("store to address %h was still stalled after %0d cycles", addr, cnt);
        end else begin
            @(posedge clk_i);                    // accepted here
            for (int i = 0; i < num_bytes(size); i++) begin
                ref_mem[addr + i] = data[8*i +: 8];
            end
        end
        #1;
        store_req_i = 1'b0;
    endtask

    // load with its own stall and response waits; stalled reports back-pressure
    task automatic load_check(input string                name,
                              input logic [ADDR_SIZE-1:0] addr,
                              input mem_size_e            size,
                              output logic                stalled);
        int                   cnt;
        logic [WORD_SIZE-1:0] exp;
        cnt         = 0;
        stalled     = 1'b0;
        req_i.addr  = addr;
        req_i.data  = '0;
        req_i.size  = size;
        store_req_i = 1'b0;
        load_req_i  = 1'b1;
        @(negedge clk_i);
        while (stall_o && cnt < TIMEOUT) begin
            stalled = 1'b1;
            cnt++;
            @(negedge clk_i);
        end
        if (stall_o) begin
            timeouts++;
            $display("%s: load from %h was never accepted", name, addr);
            load_req_i = 1'b0;
        end else begin
            exp = ref_load(addr, size);
            @(posedge clk_i);                    // accepted here
            #1;
            load_req_i = 1'b0;
            cnt        = 0;
            @(negedge clk_i);
            while (!load_valid_o && cnt < TIMEOUT) begin
                cnt++;
                @(negedge clk_i);
            end
            if (!load_valid_o) begin
                timeouts++;
                $display("%s: no load response arrived", name);
            end else begin
                checks++;
                assert (cnt == 0) else begin
                    errors++;
                    $display("%s: load response came %0d cycles late", name, cnt);
                end
                checks++;
                assert (load_data_o === exp) else begin
                    errors++;
                    $display("error %s: expected %h, actual %h", name, exp, load_data_o);
                end
            end
        end
        @(posedge clk_i);
        #1;
        checks++;                                // the response is a single pulse
        assert (load_valid_o === 1'b0) else begin
            errors++;
            $display("%s: load_valid_o stayed high after the response", name);
        end
    endtask

    task automatic test_reset();
        repeat (5) begin
            @(negedge clk_i);
            checks++;
            assert (stall_o === 1'b0 && load_valid_o === 1'b0) else begin
                errors++;
                $display("error reset: expected stall 0 valid 0, actual stall %b valid %b",
                         stall_o, load_valid_o);
            end
        end
        @(posedge clk_i);
        #1;
    endtask

    // each load right behind its store, so it finds the entry
    task automatic test_forward();
        logic [ADDR_SIZE-1:0] a_h;
        logic [ADDR_SIZE-1:0] a_b;
        logic                 st;
        a_h = 32'h084 + (($random(seed) & 1) * 2);
        a_b = 32'h088 + ($random(seed) & 3);
        store_op(32'h080, $random(seed), WORD);
        load_check("forward word", 32'h080, WORD, st);
        store_op(a_h, $random(seed), HALF);
        load_check("forward half", a_h, HALF, st);
        store_op(a_b, $random(seed), BYTE);
        load_check("forward byte", a_b, BYTE, st);
    endtask

    task automatic test_merge();
        logic st;
        store_op(32'h0a0, $random(seed), WORD);
        store_op(32'h0a0 + ($random(seed) & 3), $random(seed), BYTE);
        store_op(32'h0a0 + (($random(seed) & 1) * 2), $random(seed), HALF);
        load_check("merge", 32'h0a0, WORD, st);
    endtask

    // words 64..71 get filled first, narrow stores land on top
    task automatic test_drain();
        logic [ADDR_SIZE-1:0] a;
        mem_size_e            sz;
        logic                 st;
        for (int w = 0; w < 8; w++) begin
            store_op(32'h100 + 4*w, $random(seed), WORD);
        end
        repeat (6) begin
            sz = ($random(seed) & 1) ? HALF : BYTE;
            a  = 32'h100 + 4*($random(seed) & 7);
            a  = a + ((sz == HALF) ? (($random(seed) & 1) * 2) : ($random(seed) & 3));
            store_op(a, $random(seed), sz);
        end
        idle(4);                                 // lets the buffer empty
        for (int w = 0; w < 8; w++) begin
            load_check("drain word", 32'h100 + 4*w, WORD, st);
        end
        repeat (4) begin
            load_check("drain byte", 32'h100 + ($random(seed) & 31), BYTE, st);
        end
    endtask

    // loads from word 64 take the port between the stores
    task automatic test_full();
        logic st;
        store_op(32'h140, $random(seed), WORD);
        load_check("full load", 32'h100, WORD, st);
        store_op(32'h144, $random(seed), WORD);
        load_check("full load", 32'h100, WORD, st);
        store_op(32'h148, $random(seed), WORD);
        idle(3);
        load_check("full word a", 32'h140, WORD, st);
        load_check("full word b", 32'h144, WORD, st);
        load_check("full word c", 32'h148, WORD, st);
    endtask

    task automatic test_conflict();
        logic st;
        store_op(32'h190, $random(seed), WORD);
        idle(3);
        store_op(32'h191, $random(seed), BYTE);
        store_op(32'h190, $random(seed), WORD);  // wider than the held byte
        idle(3);
        load_check("conflict store", 32'h190, WORD, st);
        store_op(32'h190 + ($random(seed) & 3), $random(seed), BYTE);
        load_check("conflict load", 32'h190, WORD, st);
        checks++;
        assert (st) else begin
            errors++;
            $display("conflict load: a word load over a buffered byte was not stalled");
        end
    endtask

    initial begin
        seed        = 83;
        errors      = 0;
        timeouts    = 0;
        checks      = 0;
        rst_n_i     = 1'b0;
        store_req_i = 1'b0;
        load_req_i  = 1'b0;
        req_i       = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        test_reset();
        test_forward();
        test_merge();
        test_drain();
        test_full();
        test_conflict();
        idle(2);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
